// File: Makefile
# Verilator build and run for the ROM request subsystem

TOP = tb_game_rom_ctrl

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f game_rom_ctrl.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f game_rom_ctrl.f

clean:
	rm -rf obj_dir

// File: bench/game_rom_ctrl_assert.sv
// arbiter checks: one-hot refill, SDRAM request held while stalled, no valid during WAIT

`timescale 1ns/1ps

module game_rom_ctrl_assert (
    input logic                              clk,
    input logic                              rst_n,
    input sdram_rd_pkg::arb_state_e          state,
    input logic                              sd_ready,
    input sdram_rd_pkg::sdram_rd_req_t       sd_req,
    input logic [rom_cfg_pkg::NUM_SLOTS-1:0] refill_we
);
    import sdram_rd_pkg::*;

    refill_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(refill_we)
    ) else $error("refill write enable selects more than one slot");

    // stalled request keeps valid and address
    req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        sd_req.valid && !sd_ready |=> sd_req.valid && $stable(sd_req.addr)
    ) else $error("SDRAM request changed before it was accepted");

    wait_quiet: assert property (
        @(posedge clk) disable iff (!rst_n) (state == ARB_WAIT) |-> !sd_req.valid
    ) else $error("SDRAM request valid while waiting for read data");

endmodule

bind rom_arbiter game_rom_ctrl_assert u_arb_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .state     (state),
    .sd_ready  (sd_ready),
    .sd_req    (sd_req),
    .refill_we (refill_we)
);

// File: bench/sdram_rd_model.sv
// SDRAM read responder: LFSR ready stalls, variable read latency, single outstanding read

`timescale 1ns/1ps

module sdram_rd_model (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                stall_en,   // random ready stalls on
    input  sdram_rd_pkg::sdram_rd_req_t         sd_req,
    output logic                                sd_ready,
    output sdram_rd_pkg::sdram_rd_rsp_t         sd_rsp,
    output logic [sdram_rd_pkg::SDRAM_AW-1:0]   rd_addr,    // word being read
    input  logic [31:0]                         rd_data     // memory contents at rd_addr
);
    import sdram_rd_pkg::*;

    logic [31:0] lfsr;
    logic [31:0] bits;
    logic        busy;                  // read accepted, rvalid not yet sent
    logic [2:0]  lat_cnt;               // cycles left before rvalid
    logic        next_rdy;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};     // one step per bit
        end
    endtask

    // ready three times out of four when stalling
    task automatic roll_ready(output logic rdy);
        logic [31:0] r;
        rdy = 1'b1;
        if (stall_en) begin
            draw_bits(2, r);
            rdy = |r[1:0];
        end
    endtask

    initial lfsr = 32'h2263;

    always @(posedge clk) begin
        if (!rst_n) begin
            sd_ready <= 1'b0;
            sd_rsp   <= '0;
            busy     <= 1'b0;
            lat_cnt  <= '0;
        end else begin
            sd_rsp.rvalid <= 1'b0;
            if (busy) begin
                if (lat_cnt == '0) begin
                    sd_rsp.rvalid <= 1'b1;
                    sd_rsp.rdata  <= rd_data;
                    busy          <= 1'b0;
                    roll_ready(next_rdy);
                    sd_ready      <= next_rdy;
                end else begin
                    lat_cnt <= lat_cnt - 3'd1;
                end
            end else if (sd_req.valid && sd_ready) begin
                busy     <= 1'b1;       // accepted
                sd_ready <= 1'b0;       // nothing more until rvalid
                rd_addr  <= sd_req.addr;
                draw_bits(3, bits);
                lat_cnt  <= bits[2:0];
            end else begin
                roll_ready(next_rdy);
                sd_ready <= next_rdy;
            end
        end
    end

endmodule

// File: bench/tb_game_rom_ctrl.sv
// clock, reset, LFSR, reference ROM word, client stimulus and response checks of the ROM top level

`timescale 1ns/1ps

module tb_game_rom_ctrl;
    import rom_cfg_pkg::*;
    import sdram_rd_pkg::*;

    localparam int WAIT_LIMIT  = 300;   // cycles allowed per wait
    localparam int RAND_ROUNDS = 80;
    localparam int QUIET_WAIT  = 4;     // cycles watched for a stray SDRAM request

    logic                 clk;
    logic                 rst_n;
    logic                 downloading;
    logic                 loop_rst;
    logic                 stall_en;
    logic                 sd_ready;
    logic                 ready;
    rom_client_req_t      creq [NUM_SLOTS];
    rom_client_rsp_t      crsp [NUM_SLOTS];
    sdram_rd_req_t        sd_req;
    sdram_rd_rsp_t        sd_rsp;
    logic [SDRAM_AW-1:0]  rd_addr;
    logic [31:0]          rd_data;
    logic [31:0]          lfsr;
    logic [31:0]          expect_word;
    logic [SDRAM_AW-1:0]  accepted [$];     // SDRAM addresses in accept order
    logic [CLIENT_AW-1:0] last_addr [NUM_SLOTS];
    int                   valid_cycles;

    game_rom_ctrl u_game_rom_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .loop_rst    (loop_rst),
        .creq        (creq),
        .sd_ready    (sd_ready),
        .sd_rsp      (sd_rsp),
        .crsp        (crsp),
        .ready       (ready),
        .sd_req      (sd_req)
    );

    sdram_rd_model u_sdram (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall_en (stall_en),
        .sd_req   (sd_req),
        .sd_ready (sd_ready),
        .sd_rsp   (sd_rsp),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    // golden-ratio hash of the word address
    function automatic logic [31:0] rom_word(input logic [SDRAM_AW-1:0] addr);
        logic [31:0] x;
        x = 32'(addr) * 32'h9E37_79B1;
        return x ^ (x >> 13) ^ 32'h5A5A_0000;
    endfunction

    assign rd_data = rom_word(rd_addr);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};     // one step per bit
        end
    endtask

    task automatic report_fail(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // compares every data_ok and logs every SDRAM accept
    always @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (crsp[i].data_ok) begin
                    expect_word = rom_word(SDRAM_AW'(SLOT_BASE[i]) + SDRAM_AW'(creq[i].addr));
                    assert (crsp[i].data == expect_word) else report_fail($sformatf(
                        "CHECK FAILED crsp[%0d].data: got %08h expected %08h",
                        i, crsp[i].data, expect_word));
                end
            end
            if (sd_req.valid) valid_cycles++;
            if (sd_req.valid && sd_ready) accepted.push_back(sd_req.addr);
        end
    end

    // presents addresses on the masked slots and drops each valid at its data_ok
    task automatic fetch(input logic [NUM_SLOTS-1:0] mask,
                         input logic [CLIENT_AW-1:0] addrs [NUM_SLOTS], output int cycles);
        logic [NUM_SLOTS-1:0] left;
        left   = mask;
        cycles = 0;
        @(posedge clk);
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (mask[i]) creq[i] <= {1'b1, addrs[i]};
        end
        while (left != '0) begin
            @(posedge clk);
            cycles++;
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (left[i] && crsp[i].data_ok) begin
                    left[i]       = 1'b0;
                    creq[i].valid <= 1'b0;   // client done with this word
                end
            end
            assert (cycles < WAIT_LIMIT) else report_fail($sformatf(
                "timeout: slots %b never got their data", left));
        end
    endtask

    // called in the cycle the gate inputs are driven low
    task automatic check_settle();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            assert (n < WAIT_LIMIT) else report_fail("timeout: ready never came back");
        end while (!ready);
        assert (n == SETTLE_CYCLES + 1) else report_fail($sformatf(
            "CHECK FAILED ready settle cycles: got %h expected %h", n, SETTLE_CYCLES + 1));
    endtask

    task automatic pulse_loop_rst();
        @(posedge clk);
        loop_rst <= 1'b1;
        @(posedge clk);
        loop_rst <= 1'b0;
        check_settle();
    endtask

    initial begin
        logic [31:0]          r;
        logic [NUM_SLOTS-1:0] mask;
        logic [CLIENT_AW-1:0] addrs [NUM_SLOTS];
        int                   cycles;
        int                   seen;
        lfsr        = 32'h2263;
        rst_n       = 1'b0;
        downloading = 1'b1;
        loop_rst    = 1'b0;
        stall_en    = 1'b0;
        for (int i = 0; i < NUM_SLOTS; i++) creq[i] = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        for (int k = 0; k < 6; k++) begin      // still downloading
            @(posedge clk);
            assert (!ready) else report_fail($sformatf(
                "CHECK FAILED ready: got %h expected %h", ready, 1'b0));
        end
        downloading <= 1'b0;
        check_settle();
        pulse_loop_rst();

        for (int s = 0; s < NUM_SLOTS; s++) begin   // one miss per slot
            take_bits(CLIENT_AW, r);
            addrs[s] = r[CLIENT_AW-1:0];
            fetch(NUM_SLOTS'(1) << s, addrs, cycles);
            last_addr[s] = addrs[s];
        end

        for (int s = 0; s < NUM_SLOTS; s++) begin   // same address again hits
            seen     = valid_cycles;
            addrs[s] = last_addr[s];
            fetch(NUM_SLOTS'(1) << s, addrs, cycles);
            assert (cycles == 1) else report_fail($sformatf(
                "CHECK FAILED crsp[%0d].data_ok latency: got %h expected %h", s, cycles, 1));
            repeat (QUIET_WAIT) @(posedge clk);     // a stray miss would reach ISSUE by now
            assert (valid_cycles == seen) else report_fail($sformatf(
                "CHECK FAILED sd_req.valid cycles: got %h expected %h", valid_cycles, seen));
        end

        accepted.delete();                      // all three miss together
        for (int s = 0; s < NUM_SLOTS; s++) begin
            take_bits(CLIENT_AW - 1, r);
            addrs[s] = {~last_addr[s][CLIENT_AW-1], r[CLIENT_AW-2:0]};
        end
        fetch('1, addrs, cycles);
        assert (accepted.size() == NUM_SLOTS) else report_fail($sformatf(
            "CHECK FAILED accepted reads: got %h expected %h", accepted.size(), NUM_SLOTS));
        for (int s = 0; s < NUM_SLOTS; s++) begin
            assert (accepted[s] == SDRAM_AW'(SLOT_BASE[s]) + SDRAM_AW'(addrs[s]))
                else report_fail($sformatf(
                    "CHECK FAILED sd_req.addr #%0d: got %06h expected %06h",
                    s, accepted[s], SDRAM_AW'(SLOT_BASE[s]) + SDRAM_AW'(addrs[s])));
            last_addr[s] = addrs[s];
        end

        stall_en <= 1'b1;
        repeat (RAND_ROUNDS) begin
            take_bits(NUM_SLOTS, r);
            mask = r[NUM_SLOTS-1:0];
            if (mask == '0) mask = NUM_SLOTS'(1);
            for (int s = 0; s < NUM_SLOTS; s++) begin
                take_bits(CLIENT_AW, r);
                addrs[s] = r[CLIENT_AW-1:0];
                if (mask[s]) last_addr[s] = addrs[s];
            end
            fetch(mask, addrs, cycles);
        end

        pulse_loop_rst();                       // cached word must be refetched
        accepted.delete();
        addrs[0] = last_addr[0];
        fetch(NUM_SLOTS'(1), addrs, cycles);
        assert (accepted.size() == 1) else report_fail($sformatf(
            "CHECK FAILED accepted reads after loop reset: got %h expected %h",
            accepted.size(), 1));
        assert (accepted[0] == SDRAM_AW'(SLOT_BASE[0]) + SDRAM_AW'(last_addr[0]))
            else report_fail($sformatf("CHECK FAILED sd_req.addr: got %06h expected %06h",
                accepted[0], SDRAM_AW'(SLOT_BASE[0]) + SDRAM_AW'(last_addr[0])));

        @(posedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: game_rom_ctrl.f
hdl/rom_cfg_pkg.sv
hdl/sdram_rd_pkg.sv
hdl/rom_ready_ctrl.sv
hdl/rom_slot.sv
hdl/rom_arbiter.sv
hdl/game_rom_ctrl.sv
bench/sdram_rd_model.sv
bench/game_rom_ctrl_assert.sv
bench/tb_game_rom_ctrl.sv

// File: hdl/game_rom_ctrl.sv
// ROM request top level: ready controller, client slots and the SDRAM read arbiter

`timescale 1ns/1ps

module game_rom_ctrl (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            downloading,
    input  logic                            loop_rst,
    input  rom_cfg_pkg::rom_client_req_t    creq [rom_cfg_pkg::NUM_SLOTS],
    input  logic                            sd_ready,
    input  sdram_rd_pkg::sdram_rd_rsp_t     sd_rsp,
    output rom_cfg_pkg::rom_client_rsp_t    crsp [rom_cfg_pkg::NUM_SLOTS],
    output logic                            ready,
    output sdram_rd_pkg::sdram_rd_req_t     sd_req
);
    import rom_cfg_pkg::*;
    import sdram_rd_pkg::*;

    logic                 flush;            // from ready ctrl to every slot
    logic [NUM_SLOTS-1:0] miss_req;
    logic [SDRAM_AW-1:0]  miss_addr [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] refill_we;        // one-hot from the arbiter
    logic [31:0]          refill_data;

    rom_ready_ctrl u_ready (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .loop_rst    (loop_rst),
        .flush       (flush),
        .ready       (ready)
    );

    // slot i reads from its own SDRAM region
    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        localparam logic [SDRAM_AW-1:0] BASE = SDRAM_AW'(SLOT_BASE[i]);

        rom_slot u_slot (
            .clk         (clk),
            .rst_n       (rst_n),
            .flush       (flush),
            .base        (BASE),
            .creq        (creq[i]),
            .refill_we   (refill_we[i]),
            .refill_data (refill_data),
            .crsp        (crsp[i]),
            .miss_req    (miss_req[i]),
            .miss_addr   (miss_addr[i])
        );
    end

    rom_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .miss_req    (miss_req),
        .miss_addr   (miss_addr),
        .sd_ready    (sd_ready),
        .sd_rsp      (sd_rsp),
        .sd_req      (sd_req),
        .refill_we   (refill_we),
        .refill_data (refill_data)
    );

endmodule

// File: hdl/rom_arbiter.sv
// fixed-priority arbiter: picks a missing slot, runs one SDRAM read, broadcasts the refill

`timescale 1ns/1ps

module rom_arbiter (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [rom_cfg_pkg::NUM_SLOTS-1:0]   miss_req,
    input  logic [sdram_rd_pkg::SDRAM_AW-1:0]   miss_addr [rom_cfg_pkg::NUM_SLOTS],
    input  logic                                sd_ready,
    input  sdram_rd_pkg::sdram_rd_rsp_t         sd_rsp,
    output sdram_rd_pkg::sdram_rd_req_t         sd_req,
    output logic [rom_cfg_pkg::NUM_SLOTS-1:0]   refill_we,   // one-hot pulse
    output logic [31:0]                         refill_data  // shared by all slots
);
    import rom_cfg_pkg::*;
    import sdram_rd_pkg::*;

    localparam int SEL_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;

    arb_state_e           state;
    logic [SEL_W-1:0]     sel_q;        // slot being served
    logic [SDRAM_AW-1:0]  addr_q;       // its SDRAM word address
    logic [NUM_SLOTS-1:0] req_live;     // requests still needing service
    logic                 any_req;
    logic [SEL_W-1:0]     pick;         // lowest requesting index

    // a slot being written this cycle still shows its request,
    // mask it so it is not fetched twice
    assign req_live = miss_req & ~refill_we;
    assign any_req  = |req_live;

    // scan downwards so the lowest index wins
    always_comb begin
        pick = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (req_live[i]) begin
                pick = SEL_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ARB_IDLE;
            refill_we <= '0;
        end else begin
            refill_we <= '0;                // single-cycle pulse
            case (state)
                ARB_IDLE: begin
                    if (any_req) begin
                        state <= ARB_ISSUE;
                    end
                end
                ARB_ISSUE: begin
                    if (sd_ready) begin
                        state <= ARB_WAIT;  // accepted
                    end
                end
                ARB_WAIT: begin
                    if (sd_rsp.rvalid) begin
                        state     <= ARB_IDLE;
                        refill_we <= NUM_SLOTS'(1) << sel_q;
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    // winner and address latched on leaving IDLE, data on rvalid
    always_ff @(posedge clk) begin
        if (state == ARB_IDLE && any_req) begin
            sel_q  <= pick;
            addr_q <= miss_addr[pick];
        end
        if (state == ARB_WAIT && sd_rsp.rvalid) begin
            refill_data <= sd_rsp.rdata;
        end
    end

    // request held steady for the whole ISSUE state
    always_comb begin
        sd_req.valid = (state == ARB_ISSUE);
        sd_req.addr  = addr_q;
    end

endmodule

// File: hdl/rom_cfg_pkg.sv
// client-side config: slot count, address width, per-slot SDRAM regions, client request/response structs

package rom_cfg_pkg;

    // slot 0 main CPU, slot 1 objects, slot 2 characters
    localparam int NUM_SLOTS = 3;

    // client word address, 8K words of 32 bits per region
    localparam int CLIENT_AW = 13;

    // SDRAM word offset of each client's region
    localparam int unsigned SLOT_BASE [NUM_SLOTS] = '{
        32'h0000_0000,              // main CPU program
        32'h0001_0000,              // object graphics
        32'h0002_0000               // character graphics
    };

    // cycles between gate release and ready
    localparam int SETTLE_CYCLES = 8;

    // held steady by the client until data_ok
    typedef struct packed {
        logic                 valid;    // client wants a word
        logic [CLIENT_AW-1:0] addr;     // word address in own region
    } rom_client_req_t;

    // data_ok is combinational from the slot tag compare
    typedef struct packed {
        logic        data_ok;           // data matches the presented addr
        logic [31:0] data;              // whole aligned word
    } rom_client_rsp_t;

endpackage

// File: hdl/rom_ready_ctrl.sv
// readiness gate: holds flush through download/loop reset plus a settle period, registered ready

`timescale 1ns/1ps

module rom_ready_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic downloading,           // ROM being written into SDRAM
    input  logic loop_rst,              // core restart request
    output logic flush,                 // slots drop their tags
    output logic ready                  // subsystem usable
);
    import rom_cfg_pkg::*;

    localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

    logic             gate;             // either hold input high
    logic [CNT_W-1:0] settle_cnt;       // cycles left before release
    logic             settle_last;      // flush ends after this cycle

    assign gate        = downloading || loop_rst;
    assign flush       = gate || (settle_cnt != '0);
    assign settle_last = (settle_cnt <= CNT_W'(1));

    // counter reloads on every gated cycle, runs down once released
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            settle_cnt <= CNT_W'(SETTLE_CYCLES);
        end else if (gate) begin
            settle_cnt <= CNT_W'(SETTLE_CYCLES);
        end else if (settle_cnt != '0) begin
            settle_cnt <= settle_cnt - 1'b1;
        end
    end

    // ready follows the next value of flush, so it rises
    // exactly SETTLE_CYCLES cycles after the gate drops
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready <= 1'b0;
        end else begin
            ready <= !gate && settle_last;  // low again one cycle after gate rises
        end
    end

endmodule

// File: hdl/rom_slot.sv
// one client slot: cached word with tag, hit check, refill request to the arbiter

`timescale 1ns/1ps

module rom_slot (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                flush,       // invalidate tag
    input  logic [sdram_rd_pkg::SDRAM_AW-1:0]   base,        // region offset
    input  rom_cfg_pkg::rom_client_req_t        creq,
    input  logic                                refill_we,   // our refill pulse
    input  logic [31:0]                         refill_data,
    output rom_cfg_pkg::rom_client_rsp_t        crsp,
    output logic                                miss_req,    // level, held until refill
    output logic [sdram_rd_pkg::SDRAM_AW-1:0]   miss_addr
);
    import rom_cfg_pkg::*;
    import sdram_rd_pkg::*;

    logic [31:0]          data_q;       // cached word
    logic [CLIENT_AW-1:0] tag_q;        // client address of data_q
    logic                 tag_vld;
    logic                 pend;         // miss raised, refill not back yet
    logic [CLIENT_AW-1:0] req_addr;     // address the pending refill belongs to
    logic                 hit;
    logic [CLIENT_AW-1:0] fetch_addr;

    assign hit = tag_vld && (tag_q == creq.addr);

    // once pending, keep asking for the same word even if the client moves
    assign fetch_addr = pend ? req_addr : creq.addr;
    assign miss_req   = !flush && (pend || (creq.valid && !hit));
    assign miss_addr  = base + SDRAM_AW'(fetch_addr);

    always_comb begin
        crsp.data_ok = creq.valid && hit;   // same cycle on a hit
        crsp.data    = data_q;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag_vld <= 1'b0;
            pend    <= 1'b0;
        end else begin
            if (refill_we) begin
                pend <= 1'b0;               // served, even if dropped by flush
            end else if (miss_req) begin
                pend <= 1'b1;
            end
            if (flush) begin
                tag_vld <= 1'b0;
            end else if (refill_we) begin
                tag_vld <= 1'b1;
            end
        end
    end

    // first miss cycle captures the address the arbiter will fetch
    always_ff @(posedge clk) begin
        if (miss_req && !pend) begin
            req_addr <= creq.addr;
        end
        if (refill_we && !flush) begin
            data_q <= refill_data;
            tag_q  <= req_addr;
        end
    end

endmodule

// File: hdl/sdram_rd_pkg.sv
// SDRAM read channel: address width, request/response structs, arbiter FSM states

package sdram_rd_pkg;

    // word address into the 4M-word SDRAM
    localparam int SDRAM_AW = 22;

    // valid/ready handshake, ready comes in separately
    typedef struct packed {
        logic                valid;     // read request pending
        logic [SDRAM_AW-1:0] addr;      // word address
    } sdram_rd_req_t;

    // one rvalid pulse per accepted request
    typedef struct packed {
        logic        rvalid;            // rdata strobe
        logic [31:0] rdata;             // read word
    } sdram_rd_rsp_t;

    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,               // pick the next slot
        ARB_ISSUE = 2'd1,               // valid up, wait for ready
        ARB_WAIT  = 2'd2                // wait for rvalid
    } arb_state_e;

endpackage
